/* logic/mem_cfg_pkg.sv */
//######################################
// memory-side defaults: data width, depth
// BIST march state encoding
//######################################

package mem_cfg_pkg;

   //######################################
   // default geometry
   //######################################
   localparam int DW_DEFAULT    = 64;     // bits per word
   localparam int DEPTH_DEFAULT = 32;     // words in the array

   //######################################
   // march engine states
   //######################################
   typedef enum logic [2:0] {
      BIST_IDLE  = 3'd0,                  // waiting for start
      BIST_WRITE = 3'd1,                  // w(pat) ascending
      BIST_RDWR  = 3'd2,                  // r(pat) then w(~pat) ascending
      BIST_RDDN  = 3'd3,                  // r(~pat) descending
      BIST_DONE  = 3'd4                   // one-cycle wrap-up
   } bist_state_e;

endpackage

/* logic/mem_reg_pkg.sv */
//######################################
// register word types, register map
// and field positions
//######################################

package mem_reg_pkg;

   typedef logic [3:0]  reg_addr_t;       // word address
   typedef logic [31:0] reg_data_t;       // data word

   //######################################
   // register map
   //######################################
   localparam reg_addr_t ADDR_CTRL      = 4'd0;  // shutdown, start
   localparam reg_addr_t ADDR_STATUS    = 4'd1;  // ro: busy/done/fail
   localparam reg_addr_t ADDR_PATTERN   = 4'd2;  // bist seed
   localparam reg_addr_t ADDR_FAIL_ADDR = 4'd3;  // ro: first bad word

   //######################################
   // field positions
   //######################################
   localparam int CTRL_SHUTDOWN_BIT = 0;  // level
   localparam int CTRL_START_BIT    = 1;  // write-only, self clearing

   localparam int STAT_BUSY_BIT = 0;      // march running
   localparam int STAT_DONE_BIT = 1;      // sticky until next start
   localparam int STAT_FAIL_BIT = 2;      // any compare miss

endpackage

/* logic/mem_ram.sv */
//######################################
// behavioral dual-port array
// bit-masked write, registered read
//######################################

`timescale 1ns/1ps

module mem_ram #(
   parameter int DW    = 64,              // word width
   parameter int DEPTH = 32,              // word count
   localparam int AW   = $clog2(DEPTH)    // address width
) (
   input  logic          wr_clk,          // write clock
   input  logic          rst,             // clears output register only
   input  logic          wr_en,           // write enable
   input  logic [DW-1:0] wr_wem,          // per-bit write enable
   input  logic [AW-1:0] wr_addr,         // write address
   input  logic [DW-1:0] wr_din,          // write data
   input  logic          rd_clk,          // read clock, same as wr_clk
   input  logic          rd_en,           // read enable
   input  logic [AW-1:0] rd_addr,         // read address
   output logic [DW-1:0] rd_dout          // read data, one cycle after rd_en
);

   logic [DW-1:0] ram [DEPTH];            // storage, no init

   // only masked bits change
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         ram[wr_addr] <= (ram[wr_addr] & ~wr_wem) | (wr_din & wr_wem);
      end
   end

   // old data on same-address read-during-write
   always_ff @(posedge rd_clk) begin
      if (rst) begin
         rd_dout <= '0;
      end else if (rd_en) begin
         rd_dout <= ram[rd_addr];         // holds until next read
      end
   end

endmodule

/* logic/mem_dp.sv */
//######################################
// dual-port wrapper: user/BIST select,
// shutdown write block and read zeroing
//######################################

`timescale 1ns/1ps

module mem_dp #(
   parameter int DW    = 64,
   parameter int DEPTH = 32,
   localparam int AW   = $clog2(DEPTH)
) (
   input  logic          wr_clk,          // write clock
   input  logic          rst,             // sync, active high
   input  logic          wr_en,           // user write enable
   input  logic [DW-1:0] wr_wem,          // user bit mask
   input  logic [AW-1:0] wr_addr,         // user write address
   input  logic [DW-1:0] wr_din,          // user write data
   input  logic          rd_clk,          // read clock
   input  logic          rd_en,           // user read enable
   input  logic [AW-1:0] rd_addr,         // user read address
   output logic [DW-1:0] rd_dout,         // shared read data
   input  logic          shutdown,        // blocks all access
   input  logic          bist_en,         // BIST owns both ports
   input  logic          bist_we,         // BIST write enable
   input  logic [DW-1:0] bist_wem,        // BIST bit mask
   input  logic [AW-1:0] bist_addr,       // BIST address, both ports
   input  logic [DW-1:0] bist_din,        // BIST write data
   input  logic          bist_rd_en       // BIST read enable
);

   logic          ram_wr_en;
   logic [DW-1:0] ram_wem;
   logic [AW-1:0] ram_wr_addr;
   logic [DW-1:0] ram_din;
   logic          ram_rd_en;
   logic [AW-1:0] ram_rd_addr;
   logic [DW-1:0] ram_dout;
   logic          shutdown_q;             // aligned to read latency

   //######################################
   // port select
   //######################################
   assign ram_wr_en   = ~shutdown & (bist_en ? bist_we : wr_en);
   assign ram_wem     = bist_en ? bist_wem : wr_wem;
   assign ram_wr_addr = bist_en ? bist_addr : wr_addr;
   assign ram_din     = bist_en ? bist_din : wr_din;
   assign ram_rd_en   = ~shutdown & (bist_en ? bist_rd_en : rd_en);
   assign ram_rd_addr = bist_en ? bist_addr : rd_addr;

   always_ff @(posedge rd_clk) begin
      if (rst) shutdown_q <= 1'b0;
      else     shutdown_q <= shutdown;
   end

   assign rd_dout = shutdown_q ? '0 : ram_dout;   // zero after any shutdown cycle

   mem_ram #(.DW(DW), .DEPTH(DEPTH)) i_mem_ram (
      .wr_clk (wr_clk),
      .rst    (rst),
      .wr_en  (ram_wr_en),
      .wr_wem (ram_wem),
      .wr_addr(ram_wr_addr),
      .wr_din (ram_din),
      .rd_clk (rd_clk),
      .rd_en  (ram_rd_en),
      .rd_addr(ram_rd_addr),
      .rd_dout(ram_dout)
   );

endmodule

/* logic/mem_bist.sv */
//######################################
// three-pass march BIST engine
// w(p) up, r(p)w(~p) up, r(~p) down
//######################################

`timescale 1ns/1ps

module mem_bist #(
   parameter int DW    = 64,
   parameter int DEPTH = 32,
   localparam int AW   = $clog2(DEPTH)
) (
   input  logic                   wr_clk,
   input  logic                   rst,
   input  logic                   start,        // one-cycle request
   input  logic                   shutdown,     // blocks start, aborts run
   input  mem_reg_pkg::reg_data_t pattern,      // 32-bit seed
   output logic                   bist_en,      // take over the wrapper
   output logic                   bist_we,
   output logic [DW-1:0]          bist_wem,
   output logic [AW-1:0]          bist_addr,
   output logic [DW-1:0]          bist_din,
   output logic                   bist_rd_en,
   input  logic [DW-1:0]          rd_dout,      // wrapper read data
   output logic                   busy,
   output logic                   done_pulse,
   output logic                   fail,
   output logic [AW-1:0]          fail_addr
);

   localparam int            REP  = (DW + 31) / 32;  // seed copies per word
   localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

   mem_cfg_pkg::bist_state_e state;
   logic [AW-1:0]   addr;                 // march address
   logic            phase;                // rdwr: 0 read, 1 write
   logic [REP*32-1:0] pat_rep;
   logic [DW-1:0]   pat_word;             // seed across the width
   logic            cmp_vld;              // read in flight
   logic [DW-1:0]   cmp_exp;              // expected word
   logic [AW-1:0]   cmp_addr;             // address of that read
   logic            miss;
   logic            fail_q;
   logic [AW-1:0]   fail_addr_q;

   assign pat_rep  = {REP{pattern}};
   assign pat_word = pat_rep[DW-1:0];

   //######################################
   // memory side
   //######################################
   assign busy       = (state == mem_cfg_pkg::BIST_WRITE) |
                       (state == mem_cfg_pkg::BIST_RDWR)  |
                       (state == mem_cfg_pkg::BIST_RDDN);
   assign bist_en    = busy & ~shutdown;  // drop at once on shutdown
   assign bist_we    = bist_en & ((state == mem_cfg_pkg::BIST_WRITE) |
                       ((state == mem_cfg_pkg::BIST_RDWR) & phase));
   assign bist_rd_en = bist_en & ((state == mem_cfg_pkg::BIST_RDDN) |
                       ((state == mem_cfg_pkg::BIST_RDWR) & ~phase));
   assign bist_wem   = '1;                // full-word writes
   assign bist_addr  = addr;
   assign bist_din   = (state == mem_cfg_pkg::BIST_WRITE) ? pat_word : ~pat_word;

   // compare runs one cycle behind the read
   assign miss       = cmp_vld & (rd_dout != cmp_exp);
   assign fail       = fail_q | miss;     // includes the last compare in DONE
   assign fail_addr  = fail_q ? fail_addr_q : cmp_addr;
   assign done_pulse = (state == mem_cfg_pkg::BIST_DONE);

   always_ff @(posedge wr_clk) begin
      if (bist_rd_en) begin
         cmp_exp  <= (state == mem_cfg_pkg::BIST_RDDN) ? ~pat_word : pat_word;
         cmp_addr <= addr;
      end
   end

   //######################################
   // march FSM
   //######################################
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         state       <= mem_cfg_pkg::BIST_IDLE;
         addr        <= '0;
         phase       <= 1'b0;
         cmp_vld     <= 1'b0;
         fail_q      <= 1'b0;
         fail_addr_q <= '0;
      end else begin
         cmp_vld <= bist_rd_en;
         if (miss && !fail_q) begin       // keep first failing address
            fail_q      <= 1'b1;
            fail_addr_q <= cmp_addr;
         end
         case (state)
            mem_cfg_pkg::BIST_IDLE: begin
               if (start && !shutdown) begin
                  state       <= mem_cfg_pkg::BIST_WRITE;
                  addr        <= '0;
                  phase       <= 1'b0;
                  fail_q      <= 1'b0;    // new run, fresh result
                  fail_addr_q <= '0;
               end
            end
            mem_cfg_pkg::BIST_WRITE: begin
               if (addr == LAST) begin
                  state <= mem_cfg_pkg::BIST_RDWR;
                  addr  <= '0;
               end else begin
                  addr <= addr + 1'b1;
               end
            end
            mem_cfg_pkg::BIST_RDWR: begin
               phase <= ~phase;
               if (phase && addr == LAST) begin
                  state <= mem_cfg_pkg::BIST_RDDN;  // addr stays at top
               end else if (phase) begin
                  addr <= addr + 1'b1;
               end
            end
            mem_cfg_pkg::BIST_RDDN: begin
               if (addr == '0) state <= mem_cfg_pkg::BIST_DONE;
               else            addr  <= addr - 1'b1;
            end
            default: state <= mem_cfg_pkg::BIST_IDLE;  // done lasts one cycle
         endcase
         if (busy && shutdown) state <= mem_cfg_pkg::BIST_IDLE;  // abort
      end
   end

endmodule

/* logic/mem_regs.sv */
//######################################
// valid/ready register block
// ctrl, status, pattern, fail address
//######################################

`timescale 1ns/1ps

module mem_regs #(
   parameter int DEPTH = 32,
   localparam int AW   = $clog2(DEPTH)
) (
   input  logic                   wr_clk,
   input  logic                   rst,
   input  logic                   reg_valid,       // request present
   output logic                   reg_ready,       // low for a cycle after a transfer
   input  logic                   reg_write,       // 1 write, 0 read
   input  mem_reg_pkg::reg_addr_t reg_addr,
   input  mem_reg_pkg::reg_data_t reg_wdata,
   output logic                   reg_rvalid,      // one cycle after read accept
   output mem_reg_pkg::reg_data_t reg_rdata,
   output logic                   shutdown,
   output logic                   bist_start,      // one-cycle pulse
   output mem_reg_pkg::reg_data_t bist_pattern,
   input  logic                   bist_busy,
   input  logic                   bist_done_pulse,
   input  logic                   bist_fail,
   input  logic [AW-1:0]          bist_fail_addr
);

   logic                   xfer;           // accepted transfer
   logic                   wr_ctrl;
   logic                   stat_done;
   logic                   stat_fail;
   logic [AW-1:0]          fail_addr_q;
   mem_reg_pkg::reg_data_t rd_mux;

   assign xfer    = reg_valid & reg_ready;
   assign wr_ctrl = xfer & reg_write & (reg_addr == mem_reg_pkg::ADDR_CTRL);

   //######################################
   // handshake and control
   //######################################
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         reg_ready    <= 1'b1;
         reg_rvalid   <= 1'b0;
         shutdown     <= 1'b0;
         bist_start   <= 1'b0;
         bist_pattern <= '0;
      end else begin
         reg_ready  <= ~xfer;              // one in flight
         reg_rvalid <= xfer & ~reg_write;
         bist_start <= wr_ctrl & reg_wdata[mem_reg_pkg::CTRL_START_BIT];
         if (wr_ctrl) shutdown <= reg_wdata[mem_reg_pkg::CTRL_SHUTDOWN_BIT];
         if (xfer && reg_write && reg_addr == mem_reg_pkg::ADDR_PATTERN) begin
            bist_pattern <= reg_wdata;
         end
      end
   end

   //######################################
   // status capture
   //######################################
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         stat_done   <= 1'b0;
         stat_fail   <= 1'b0;
         fail_addr_q <= '0;
      end else if (bist_start && !shutdown && !bist_busy) begin
         stat_done   <= 1'b0;              // start the engine accepts
         stat_fail   <= 1'b0;
         fail_addr_q <= '0;
      end else if (bist_done_pulse) begin
         stat_done   <= 1'b1;
         stat_fail   <= bist_fail;
         fail_addr_q <= bist_fail ? bist_fail_addr : '0;
      end
   end

   // read decode, unmapped reads zero
   always_comb begin
      rd_mux = '0;
      case (reg_addr)
         mem_reg_pkg::ADDR_CTRL:
            rd_mux[mem_reg_pkg::CTRL_SHUTDOWN_BIT] = shutdown;  // start reads 0
         mem_reg_pkg::ADDR_STATUS: begin
            rd_mux[mem_reg_pkg::STAT_BUSY_BIT] = bist_busy;
            rd_mux[mem_reg_pkg::STAT_DONE_BIT] = stat_done;
            rd_mux[mem_reg_pkg::STAT_FAIL_BIT] = stat_fail;
         end
         mem_reg_pkg::ADDR_PATTERN:   rd_mux = bist_pattern;
         mem_reg_pkg::ADDR_FAIL_ADDR: rd_mux = mem_reg_pkg::reg_data_t'(fail_addr_q);
         default:                     rd_mux = '0;
      endcase
   end

   always_ff @(posedge wr_clk) begin
      if (xfer && !reg_write) reg_rdata <= rd_mux;
   end

endmodule

/* logic/mem_subsys.sv */
//######################################
// memory subsystem top
// register block, BIST engine, wrapper
//######################################

`timescale 1ns/1ps

module mem_subsys #(
   parameter int DW    = mem_cfg_pkg::DW_DEFAULT,
   parameter int DEPTH = mem_cfg_pkg::DEPTH_DEFAULT,
   localparam int AW   = $clog2(DEPTH)
) (
   input  logic                   wr_clk,
   input  logic                   rd_clk,      // tied to wr_clk outside
   input  logic                   rst,
   // user memory ports
   input  logic                   wr_en,
   input  logic [DW-1:0]          wr_wem,
   input  logic [AW-1:0]          wr_addr,
   input  logic [DW-1:0]          wr_din,
   input  logic                   rd_en,
   input  logic [AW-1:0]          rd_addr,
   output logic [DW-1:0]          rd_dout,
   // register port
   input  logic                   reg_valid,
   output logic                   reg_ready,
   input  logic                   reg_write,
   input  mem_reg_pkg::reg_addr_t reg_addr,
   input  mem_reg_pkg::reg_data_t reg_wdata,
   output logic                   reg_rvalid,
   output mem_reg_pkg::reg_data_t reg_rdata
);

   logic                   shutdown;
   logic                   bist_start;
   mem_reg_pkg::reg_data_t bist_pattern;
   logic                   bist_busy;
   logic                   bist_done_pulse;
   logic                   bist_fail;
   logic [AW-1:0]          bist_fail_addr;
   logic                   bist_en;
   logic                   bist_we;
   logic [DW-1:0]          bist_wem;
   logic [AW-1:0]          bist_addr;
   logic [DW-1:0]          bist_din;
   logic                   bist_rd_en;

   mem_regs #(.DEPTH(DEPTH)) i_mem_regs (
      .wr_clk         (wr_clk),
      .rst            (rst),
      .reg_valid      (reg_valid),
      .reg_ready      (reg_ready),
      .reg_write      (reg_write),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .reg_rvalid     (reg_rvalid),
      .reg_rdata      (reg_rdata),
      .shutdown       (shutdown),
      .bist_start     (bist_start),
      .bist_pattern   (bist_pattern),
      .bist_busy      (bist_busy),
      .bist_done_pulse(bist_done_pulse),
      .bist_fail      (bist_fail),
      .bist_fail_addr (bist_fail_addr)
   );

   mem_bist #(.DW(DW), .DEPTH(DEPTH)) i_mem_bist (
      .wr_clk    (wr_clk),
      .rst       (rst),
      .start     (bist_start),
      .shutdown  (shutdown),
      .pattern   (bist_pattern),
      .bist_en   (bist_en),
      .bist_we   (bist_we),
      .bist_wem  (bist_wem),
      .bist_addr (bist_addr),
      .bist_din  (bist_din),
      .bist_rd_en(bist_rd_en),
      .rd_dout   (rd_dout),                // compare sees wrapper output
      .busy      (bist_busy),
      .done_pulse(bist_done_pulse),
      .fail      (bist_fail),
      .fail_addr (bist_fail_addr)
   );

   mem_dp #(.DW(DW), .DEPTH(DEPTH)) i_mem_dp (
      .wr_clk    (wr_clk),
      .rst       (rst),
      .wr_en     (wr_en),
      .wr_wem    (wr_wem),
      .wr_addr   (wr_addr),
      .wr_din    (wr_din),
      .rd_clk    (rd_clk),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_dout   (rd_dout),
      .shutdown  (shutdown),
      .bist_en   (bist_en),
      .bist_we   (bist_we),
      .bist_wem  (bist_wem),
      .bist_addr (bist_addr),
      .bist_din  (bist_din),
      .bist_rd_en(bist_rd_en)
   );

endmodule

/* bench/mem_subsys_assert.sv */
//########################################
// concurrent checks bound to mem_subsys
// register handshake, shutdown gating
//########################################

`timescale 1ns/1ps

module mem_subsys_assert #(
   parameter int DW = 64
) (
   input logic          clk,
   input logic          rst,
   input logic          reg_valid,
   input logic          reg_ready,
   input logic          reg_write,
   input logic          reg_rvalid,
   input logic          shutdown,           // internal level from mem_regs
   input logic          bist_en,
   input logic          bist_busy,          // march engine running
   input logic [DW-1:0] rd_dout
);

   int   fail_cnt = 0;                      // failed assertions so far
   logic xfer;

   assign xfer = reg_valid & reg_ready;

   rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
      xfer && !reg_write |=> reg_rvalid)
      else begin
         fail_cnt++;
         $error("no reg_rvalid one cycle after an accepted read");
      end

   rvalid_only_read: assert property (@(posedge clk) disable iff (rst)
      reg_rvalid |-> $past(xfer && !reg_write))
      else begin
         fail_cnt++;
         $error("reg_rvalid without an accepted read one cycle before");
      end

   ready_drop: assert property (@(posedge clk) disable iff (rst)
      xfer |=> !reg_ready)
      else begin
         fail_cnt++;
         $error("reg_ready high in the cycle after a transfer");
      end

   dout_zero: assert property (@(posedge clk) disable iff (rst)
      shutdown |=> rd_dout == '0)
      else begin
         fail_cnt++;
         $error("rd_dout not zero in the cycle after shutdown");
      end

   // engine stopped, not just masked
   no_bist_off: assert property (@(posedge clk) disable iff (rst)
      shutdown |=> !bist_en && !bist_busy)
      else begin
         fail_cnt++;
         $error("BIST still active in the cycle after shutdown");
      end

endmodule

bind mem_subsys mem_subsys_assert #(.DW(DW)) i_mem_subsys_assert (
   .clk       (wr_clk),
   .rst       (rst),
   .reg_valid (reg_valid),
   .reg_ready (reg_ready),
   .reg_write (reg_write),
   .reg_rvalid(reg_rvalid),
   .shutdown  (shutdown),
   .bist_en   (bist_en),
   .bist_busy (bist_busy),
   .rd_dout   (rd_dout)
);

/* bench/mem_subsys_tb.sv */
//########################################
// testbench for mem_subsys: clock, reset,
// shadow memory, register tasks, timeout
// masked rw, regs, shutdown, BIST pass/fail
//########################################

`timescale 1ns/1ps

module mem_subsys_tb;

   localparam int DW         = mem_cfg_pkg::DW_DEFAULT;
   localparam int DEPTH      = mem_cfg_pkg::DEPTH_DEFAULT;
   localparam int AW         = $clog2(DEPTH);
   localparam int N_RAND     = 64;       // masked rw cycles
   localparam int MAX_CYCLES = 5000;     // 2 marches ~2*5*DEPTH + traffic + polls, wide margin

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   wr_en;
   logic [DW-1:0]          wr_wem;
   logic [AW-1:0]          wr_addr;
   logic [DW-1:0]          wr_din;
   logic                   rd_en;
   logic [AW-1:0]          rd_addr;
   logic [DW-1:0]          rd_dout;
   logic                   reg_valid;
   logic                   reg_ready;
   logic                   reg_write;
   mem_reg_pkg::reg_addr_t reg_addr;
   mem_reg_pkg::reg_data_t reg_wdata;
   logic                   reg_rvalid;
   mem_reg_pkg::reg_data_t reg_rdata;

   logic [DW-1:0] shadow [DEPTH];         // expected array contents
   integer        seed = 32'h07a64c3f;
   int            cycles = 0;
   int            checks = 0;
   int            errors = 0;
   int            tests = 0;
   int            test_errs = 0;          // errors when test began

   always #4 clk = ~clk;                  // 8 ns, both ports

   mem_subsys #(.DW(DW), .DEPTH(DEPTH)) i_mem_subsys (
      .wr_clk(clk), .rd_clk(clk), .rst(rst),
      .wr_en(wr_en), .wr_wem(wr_wem), .wr_addr(wr_addr), .wr_din(wr_din),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_dout(rd_dout),
      .reg_valid(reg_valid), .reg_ready(reg_ready), .reg_write(reg_write),
      .reg_addr(reg_addr), .reg_wdata(reg_wdata),
      .reg_rvalid(reg_rvalid), .reg_rdata(reg_rdata)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic step();
      @(posedge clk);
      #1;                                 // drive and sample off the edge
   endtask

   function automatic logic [DW-1:0] rand_word();
      logic [DW-1:0] w;
      w = '0;
      for (int i = 0; i < DW; i += 32) begin
         w = (w << 32) | DW'($unsigned($random(seed)));
      end
      return w;
   endfunction

   function automatic logic [AW-1:0] rand_addr();
      return AW'($unsigned($random(seed)) % DEPTH);
   endfunction

   // 32-bit seed copied across the word
   function automatic logic [DW-1:0] spread(input mem_reg_pkg::reg_data_t p);
      logic [DW-1:0] w;
      for (int i = 0; i < DW; i++) begin
         w[i] = p[i % 32];
      end
      return w;
   endfunction

   task automatic check_value(input string what, input logic [DW-1:0] exp,
                              input logic [DW-1:0] got);
      checks++;
      value_ok: assert (got === exp) else begin
         errors++;
         $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      end
   endtask

   task automatic write_reg(input mem_reg_pkg::reg_addr_t a,
                            input mem_reg_pkg::reg_data_t d);
      reg_valid = 1'b1;
      reg_write = 1'b1;
      reg_addr  = a;
      reg_wdata = d;
      while (!reg_ready) begin
         step();
      end
      step();                             // accepted at this edge
      reg_valid = 1'b0;
   endtask

   task automatic read_reg(input mem_reg_pkg::reg_addr_t a,
                           output mem_reg_pkg::reg_data_t d);
      reg_valid = 1'b1;
      reg_write = 1'b0;
      reg_addr  = a;
      while (!reg_ready) begin
         step();
      end
      step();
      reg_valid = 1'b0;
      checks++;
      rvalid_ok: assert (reg_rvalid === 1'b1) else begin
         errors++;
         $display("no read response one cycle after reading register %0d", a);
      end
      d = reg_rdata;
   endtask

   task automatic poll_done(output mem_reg_pkg::reg_data_t st);
      do begin
         read_reg(mem_reg_pkg::ADDR_STATUS, st);
      end while (!st[mem_reg_pkg::STAT_DONE_BIT]);
   endtask

   task automatic sweep_reads(input string what);
      for (int a = 0; a < DEPTH; a++) begin
         rd_en   = 1'b1;
         rd_addr = AW'(a);
         step();
         check_value($sformatf("%s, addr %0d", what, a), shadow[a], rd_dout);
      end
      rd_en = 1'b0;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_errs) $display("test %0d %s: ok", tests, name);
      else $display("test %0d %s: %0d errors", tests, name, errors - test_errs);
      test_errs = errors;
   endtask

   initial begin : main
      mem_reg_pkg::reg_data_t pat;
      mem_reg_pkg::reg_data_t st;
      mem_reg_pkg::reg_data_t rd;
      logic [DW-1:0]          pend_word;  // data due one cycle after rd_en
      logic [DW-1:0]          bad_word;
      logic [AW-1:0]          fault;
      int                     asrt;

      rst       = 1'b1;
      wr_en     = 1'b0;
      wr_wem    = '0;
      wr_addr   = '0;
      wr_din    = '0;
      rd_en     = 1'b0;
      rd_addr   = '0;
      reg_valid = 1'b0;
      reg_write = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      //########################################
      // masked writes and reads
      //########################################
      for (int a = 0; a < DEPTH; a++) begin
         wr_en     = 1'b1;                // full fill, no unknown words
         wr_wem    = '1;
         wr_addr   = AW'(a);
         wr_din    = rand_word();
         shadow[a] = wr_din;
         step();
      end
      for (int i = 0; i < N_RAND; i++) begin
         if (i > 0) check_value("masked read", pend_word, rd_dout);
         wr_addr = rand_addr();
         wr_wem  = rand_word();
         wr_din  = rand_word();
         rd_en   = 1'b1;
         rd_addr = (i % 4 == 0) ? wr_addr : rand_addr();  // some read-during-write
         pend_word = shadow[rd_addr];     // old data on collision
         for (int b = 0; b < DW; b++) begin
            if (wr_wem[b]) shadow[wr_addr][b] = wr_din[b];  // selected bits only
         end
         step();
      end
      wr_en = 1'b0;
      rd_en = 1'b0;
      check_value("masked read", pend_word, rd_dout);
      end_test("masked_rw");

      //########################################
      // register access
      //########################################
      pat = $random(seed);
      write_reg(mem_reg_pkg::ADDR_PATTERN, pat);
      read_reg(mem_reg_pkg::ADDR_PATTERN, rd);
      check_value("pattern readback", pat, rd);
      read_reg(4'hA, rd);                 // unmapped
      check_value("unmapped read", '0, rd);
      read_reg(mem_reg_pkg::ADDR_STATUS, rd);
      check_value("status after reset", '0, rd);
      end_test("registers");

      //########################################
      // shutdown
      //########################################
      write_reg(mem_reg_pkg::ADDR_CTRL, 32'(1) << mem_reg_pkg::CTRL_SHUTDOWN_BIT);
      for (int i = 0; i < 8; i++) begin
         wr_en   = 1'b1;                  // must not land
         wr_wem  = '1;
         wr_addr = rand_addr();
         wr_din  = rand_word();
         rd_en   = 1'b1;
         rd_addr = rand_addr();
         step();
         check_value("read in shutdown", '0, rd_dout);
      end
      wr_en = 1'b0;
      rd_en = 1'b0;
      write_reg(mem_reg_pkg::ADDR_CTRL, 32'h3);      // shutdown + start
      read_reg(mem_reg_pkg::ADDR_STATUS, rd);
      check_value("status, start in shutdown", '0, rd);
      write_reg(mem_reg_pkg::ADDR_CTRL, 32'h0);
      sweep_reads("after shutdown");
      end_test("shutdown");

      //########################################
      // BIST pass
      //########################################
      pat = $random(seed);
      write_reg(mem_reg_pkg::ADDR_PATTERN, pat);
      write_reg(mem_reg_pkg::ADDR_CTRL, 32'(1) << mem_reg_pkg::CTRL_START_BIT);
      step();                             // engine busy from here
      for (int i = 0; i < 16; i++) begin
         wr_en   = 1'b1;                  // ignored while BIST owns the array
         wr_wem  = '1;
         wr_addr = rand_addr();
         wr_din  = rand_word();
         step();
      end
      wr_en = 1'b0;
      poll_done(st);
      check_value("status after pass", 32'(1) << mem_reg_pkg::STAT_DONE_BIT, st);
      read_reg(mem_reg_pkg::ADDR_FAIL_ADDR, rd);
      check_value("fail addr after pass", '0, rd);
      for (int a = 0; a < DEPTH; a++) begin
         shadow[a] = ~spread(pat);
      end
      sweep_reads("after BIST");
      end_test("bist_pass");

      //########################################
      // BIST fail, one corrupted compare
      //########################################
      pat      = $random(seed);
      fault    = rand_addr();
      bad_word = spread(pat) ^ (DW'(1) << ($unsigned($random(seed)) % DW));
      write_reg(mem_reg_pkg::ADDR_PATTERN, pat);
      write_reg(mem_reg_pkg::ADDR_CTRL, 32'(1) << mem_reg_pkg::CTRL_START_BIT);
      while (!(i_mem_subsys.bist_rd_en && i_mem_subsys.bist_addr == fault)) begin
         step();                          // first hit is the ascending read pass
      end
      step();                             // array data for that read now out
      force i_mem_subsys.i_mem_dp.ram_dout = bad_word;
      step();
      release i_mem_subsys.i_mem_dp.ram_dout;
      poll_done(st);
      check_value("status after fail", (32'(1) << mem_reg_pkg::STAT_DONE_BIT) |
                  (32'(1) << mem_reg_pkg::STAT_FAIL_BIT), st);
      read_reg(mem_reg_pkg::ADDR_FAIL_ADDR, rd);
      check_value("fail addr", DW'(fault), rd);
      for (int a = 0; a < DEPTH; a++) begin
         shadow[a] = ~spread(pat);
      end
      sweep_reads("after failing BIST");
      end_test("bist_fail");

      asrt = i_mem_subsys.i_mem_subsys_assert.fail_cnt;
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               tests, checks, errors, asrt);
      if (errors == 0 && asrt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* mem_subsys.f */
logic/mem_cfg_pkg.sv
logic/mem_reg_pkg.sv
logic/mem_ram.sv
logic/mem_dp.sv
logic/mem_bist.sv
logic/mem_regs.sv
logic/mem_subsys.sv
bench/mem_subsys_assert.sv
bench/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - logic/mem_cfg_pkg.sv
  - logic/mem_reg_pkg.sv
  - logic/mem_ram.sv
  - logic/mem_dp.sv
  - logic/mem_bist.sv
  - logic/mem_regs.sv
  - logic/mem_subsys.sv
  - target: test
    files:
      - bench/mem_subsys_assert.sv
      - bench/mem_subsys_tb.sv
